// ==== flist.f ====
rtl/tlb_pkg.sv
rtl/tlb_match_single.sv
rtl/tlb_key_array.sv
rtl/tlb_hit_encoder.sv
rtl/tlb_translate_stage.sv
rtl/tlb_update_ctrl.sv
rtl/tlb_lookup_top.sv
testbench/tb_tlb_lookup_top.sv

// ==== rtl/tlb_hit_encoder.sv ====
module tlb_hit_encoder import tlb_pkg::*; (
  input  logic     clk,
  input  logic     reset_i,
  input  logic     valid_i,
  input  vaddr_t   vaddr_i,
  input  hit_vec_t hit_i,
  input  hit_vec_t huge_i,
  output logic     valid_o,
  output stage1_t  stage_o
);

  stage1_t  stage_d;
  tlb_idx_t enc_idx;

  // lowest set bit wins, loop runs downward so the last write is the lowest
  always_comb begin
    enc_idx = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (hit_i[i]) begin
        enc_idx = tlb_idx_t'(i);
      end
    end
  end

  always_comb begin
    stage_d.hit       = |hit_i;
    // more than one bit set if clearing the lowest leaves something
    stage_d.multi_hit = |(hit_i & (hit_i - 1'b1));
    stage_d.idx       = enc_idx;
    stage_d.huge      = huge_i[enc_idx] & stage_d.hit;
    stage_d.vaddr     = vaddr_i;
  end

  // stage 1 valid
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // stage 1 payload
  always_ff @(posedge clk) begin
    stage_o <= stage_d;
  end

  assert property (@(posedge clk) disable iff (reset_i)
    valid_o && stage_o.multi_hit |-> stage_o.hit);

endmodule

// ==== rtl/tlb_key_array.sv ====
module tlb_key_array import tlb_pkg::*; (
  input  logic        clk,
  input  logic        reset_i,
  input  lookup_req_t lookup_req_i,
  input  logic        wr_en_i,
  input  tlb_idx_t    wr_idx_i,
  input  tlb_key_t    wr_key_i,
  // one match bit per entry, combinational from lookup_req_i
  output hit_vec_t    hit_o,
  // registered page size flag per entry
  output hit_vec_t    huge_o
);

  // page number part of the lookup address
  vppn_t    lookup_vppn;
  // per-entry write strobes
  hit_vec_t entry_wr_en;

  assign lookup_vppn = lookup_req_i.vaddr[31:SMALL_PS];

  // one-hot decode of the refill index
  always_comb begin
    entry_wr_en = '0;
    if (wr_en_i) begin
      entry_wr_en[wr_idx_i] = 1'b1;
    end
  end

  // all entries searched in parallel
  for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_entry
    tlb_match_single i_tlb_match_single (
      .clk          (clk),
      .reset_i      (reset_i),
      .lookup_vppn_i(lookup_vppn),
      .lookup_asid_i(lookup_req_i.asid),
      .wr_en_i      (entry_wr_en[i]),
      .wr_key_i     (wr_key_i),
      .match_o      (hit_o[i]),
      .huge_o       (huge_o[i])
    );
  end

endmodule

// ==== rtl/tlb_lookup_top.sv ====
module tlb_lookup_top import tlb_pkg::*; (
  input  logic         clk,
  input  logic         reset_i,
  // lookup stream, no back-pressure
  input  logic         lookup_valid_i,
  input  lookup_req_t  lookup_req_i,
  // response two register stages later
  output logic         resp_valid_o,
  output lookup_resp_t resp_o,
  // refill port, four-phase req/ack
  input  logic         update_req_i,
  input  update_req_t  update_i,
  output logic         update_ack_o
);

  // write path from refill control
  logic       wr_en;
  tlb_idx_t   wr_idx;
  tlb_key_t   wr_key;
  tlb_value_t wr_value;

  // combinational search result
  hit_vec_t   hit_vec;
  hit_vec_t   huge_vec;

  // stage 1 register
  logic       s1_valid;
  stage1_t    s1;

  tlb_update_ctrl i_tlb_update_ctrl (
    .clk         (clk),
    .reset_i     (reset_i),
    .update_req_i(update_req_i),
    .update_i    (update_i),
    .update_ack_o(update_ack_o),
    .wr_en_o     (wr_en),
    .wr_idx_o    (wr_idx),
    .wr_key_o    (wr_key),
    .wr_value_o  (wr_value)
  );

  tlb_key_array i_tlb_key_array (
    .clk         (clk),
    .reset_i     (reset_i),
    .lookup_req_i(lookup_req_i),
    .wr_en_i     (wr_en),
    .wr_idx_i    (wr_idx),
    .wr_key_i    (wr_key),
    .hit_o       (hit_vec),
    .huge_o      (huge_vec)
  );

  tlb_hit_encoder i_tlb_hit_encoder (
    .clk    (clk),
    .reset_i(reset_i),
    .valid_i(lookup_valid_i),
    .vaddr_i(lookup_req_i.vaddr),
    .hit_i  (hit_vec),
    .huge_i (huge_vec),
    .valid_o(s1_valid),
    .stage_o(s1)
  );

  tlb_translate_stage i_tlb_translate_stage (
    .clk         (clk),
    .reset_i     (reset_i),
    .valid_i     (s1_valid),
    .stage_i     (s1),
    .wr_en_i     (wr_en),
    .wr_idx_i    (wr_idx),
    .wr_value_i  (wr_value),
    .resp_valid_o(resp_valid_o),
    .resp_o      (resp_o)
  );

endmodule

// ==== rtl/tlb_match_single.sv ====
module tlb_match_single import tlb_pkg::*; (
  input  logic     clk,
  input  logic     reset_i,
  input  vppn_t    lookup_vppn_i,
  input  asid_t    lookup_asid_i,
  input  logic     wr_en_i,
  input  tlb_key_t wr_key_i,
  // purely combinational, no register on the match path
  output logic     match_o,
  output logic     huge_o
);

  tlb_key_t key_q;
  // page size decoded once at write time
  logic     huge_q;

  logic match_high;
  logic match_low;
  logic match_asid;

  // only e is cleared on reset
  always_ff @(posedge clk) begin
    if (reset_i) begin
      key_q.e <= 1'b0;
    end else if (wr_en_i) begin
      key_q  <= wr_key_i;
      huge_q <= (wr_key_i.ps == ps_t'(HUGE_PS));
    end
  end

  // upper vppn bits, compared for both page sizes
  assign match_high = key_q.vppn[18:HUGE_PS-SMALL_PS]
                      == lookup_vppn_i[18:HUGE_PS-SMALL_PS];
  // lower vppn bits, ignored for huge pages
  assign match_low  = key_q.vppn[HUGE_PS-SMALL_PS-1:0]
                      == lookup_vppn_i[HUGE_PS-SMALL_PS-1:0];
  assign match_asid = (key_q.asid == lookup_asid_i);

  // global entries skip the asid compare
  assign match_o = key_q.e
                   && match_high
                   && (huge_q || match_low)
                   && (key_q.g || match_asid);

  // huge flag only meaningful when match_o is set
  assign huge_o = huge_q;

endmodule

// ==== rtl/tlb_pkg.sv ====
package tlb_pkg;

  // table geometry
  localparam int NUM_ENTRIES = 16;
  localparam int IDX_W       = 4;

  // page size encodings, also the page offset widths
  // 8 KiB small page
  localparam int SMALL_PS = 13;
  // 8 MiB huge page
  localparam int HUGE_PS  = 23;

  // address and field widths
  typedef logic [31:0] vaddr_t;
  typedef logic [31:0] paddr_t;
  // vaddr bits 31:13
  typedef logic [18:0] vppn_t;
  typedef logic [18:0] ppn_t;
  typedef logic [9:0]  asid_t;
  typedef logic [5:0]  ps_t;
  typedef logic [IDX_W-1:0] tlb_idx_t;
  // one bit per entry
  typedef logic [NUM_ENTRIES-1:0] hit_vec_t;

  // searchable half of an entry
  typedef struct packed {
    logic  e;
    vppn_t vppn;
    ps_t   ps;
    logic  g;
    asid_t asid;
  } tlb_key_t;

  // translation half of an entry
  typedef struct packed {
    ppn_t ppn;
    logic v;
    logic d;
  } tlb_value_t;

  typedef struct packed {
    vaddr_t vaddr;
    asid_t  asid;
  } lookup_req_t;

  typedef struct packed {
    logic     hit;
    logic     multi_hit;
    tlb_idx_t idx;
    paddr_t   paddr;
    logic     v;
    logic     d;
  } lookup_resp_t;

  // refill payload, held stable while req is high
  typedef struct packed {
    tlb_idx_t   idx;
    tlb_key_t   key;
    tlb_value_t value;
  } update_req_t;

  // encoder to translate stage
  typedef struct packed {
    logic     hit;
    logic     multi_hit;
    tlb_idx_t idx;
    logic     huge;
    vaddr_t   vaddr;
  } stage1_t;

  typedef enum logic [1:0] {
    UPD_IDLE,
    UPD_WRITE,
    UPD_ACK
  } update_state_t;

endpackage

// ==== rtl/tlb_translate_stage.sv ====
module tlb_translate_stage import tlb_pkg::*; (
  input  logic         clk,
  input  logic         reset_i,
  input  logic         valid_i,
  input  stage1_t      stage_i,
  input  logic         wr_en_i,
  input  tlb_idx_t     wr_idx_i,
  input  tlb_value_t   wr_value_i,
  output logic         resp_valid_o,
  output lookup_resp_t resp_o
);

  tlb_value_t   value_q [NUM_ENTRIES];

  // value write trails the key write by one cycle
  // so a lookup that matched the old key still reads the old value
  logic         wr_en_q;
  tlb_idx_t     wr_idx_q;
  tlb_value_t   wr_value_q;

  tlb_value_t   rd_value;
  lookup_resp_t resp_d;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_en_q <= 1'b0;
    end else begin
      wr_en_q <= wr_en_i;
    end
  end

  always_ff @(posedge clk) begin
    wr_idx_q   <= wr_idx_i;
    wr_value_q <= wr_value_i;
  end

  // value array, no reset
  always_ff @(posedge clk) begin
    if (wr_en_q) begin
      value_q[wr_idx_q] <= wr_value_q;
    end
  end

  assign rd_value = value_q[stage_i.idx];

  // address formation by page size, zeroed on a miss
  always_comb begin
    resp_d           = '0;
    resp_d.hit       = stage_i.hit;
    resp_d.multi_hit = stage_i.multi_hit;
    if (stage_i.hit) begin
      resp_d.idx = stage_i.idx;
      resp_d.v   = rd_value.v;
      resp_d.d   = rd_value.d;
      if (stage_i.huge) begin
        // ppn 18:10 then 23-bit offset
        resp_d.paddr = {rd_value.ppn[18:HUGE_PS-SMALL_PS], stage_i.vaddr[HUGE_PS-1:0]};
      end else begin
        // full ppn then 13-bit offset
        resp_d.paddr = {rd_value.ppn, stage_i.vaddr[SMALL_PS-1:0]};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    resp_o <= resp_d;
  end

  assert property (@(posedge clk) disable iff (reset_i)
    resp_valid_o && !resp_o.hit |-> resp_o.paddr == '0);

endmodule

// ==== rtl/tlb_update_ctrl.sv ====
module tlb_update_ctrl import tlb_pkg::*; (
  input  logic        clk,
  input  logic        reset_i,
  input  logic        update_req_i,
  input  update_req_t update_i,
  output logic        update_ack_o,
  output logic        wr_en_o,
  output tlb_idx_t    wr_idx_o,
  output tlb_key_t    wr_key_o,
  output tlb_value_t  wr_value_o
);

  update_state_t state_q;
  update_state_t state_d;

  // four-phase refill
  // idle -> write for one cycle -> ack until req drops
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      UPD_IDLE: begin
        if (update_req_i) begin
          state_d = UPD_WRITE;
        end
      end
      UPD_WRITE: begin
        state_d = UPD_ACK;
      end
      UPD_ACK: begin
        // hold ack until requester releases req
        if (!update_req_i) begin
          state_d = UPD_IDLE;
        end
      end
      default: begin
        state_d = UPD_IDLE;
      end
    endcase
  end

  // ack and write strobe registered alongside the state
  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q      <= UPD_IDLE;
      update_ack_o <= 1'b0;
      wr_en_o      <= 1'b0;
    end else begin
      state_q      <= state_d;
      update_ack_o <= (state_d == UPD_ACK);
      wr_en_o      <= (state_d == UPD_WRITE);
    end
  end

  // payload straight from the port, stable while req is high
  assign wr_idx_o   = update_i.idx;
  assign wr_key_o   = update_i.key;
  assign wr_value_o = update_i.value;

  assert property (@(posedge clk) disable iff (reset_i)
    state_q == UPD_IDLE |-> !update_ack_o);

  // single write pulse per refill
  assert property (@(posedge clk) disable iff (reset_i)
    wr_en_o |=> !wr_en_o);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the TLB lookup testbench with Verilator
set -e
cd "$(dirname "$0")"

TOP=tb_tlb_lookup_top
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module "$TOP" \
  -f flist.f \
  -o "V$TOP"

# result is taken from the log
status=0
"./obj_dir/V$TOP" > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "^All tests passed$" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, exit status $status"
exit 1

// ==== testbench/tb_tlb_lookup_top.sv ====
module tb_tlb_lookup_top import tlb_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS        = 17;
  localparam int NUM_REFILLS     = 7;
  localparam int NUM_RANDOM      = 64;
  localparam int WATCHDOG_CYCLES = (NUM_ROWS + NUM_RANDOM + NUM_REFILLS) * 10;

  // one lookup of the table with its hand-computed response
  typedef struct packed {
    vaddr_t       vaddr;
    asid_t        asid;
    lookup_resp_t exp;
  } row_t;

  // lookup in flight, with the cycle it was driven in
  typedef struct packed {
    lookup_resp_t resp;
    logic [31:0]  issue_cycle;
  } pending_t;

  logic         clk = 1'b0;
  logic         reset_i;
  logic         lookup_valid_i;
  lookup_req_t  lookup_req_i;
  logic         resp_valid_o;
  lookup_resp_t resp_o;
  logic         update_req_i;
  update_req_t  update_i;
  logic         update_ack_o;

  row_t         rows[$];
  string        row_names[$];
  update_req_t  refills[$];
  // row index each refill goes in front of
  int           refill_at[$];
  pending_t     pending_q[$];
  string        pending_names[$];
  int unsigned  cycle_cnt = 0;

  tlb_lookup_top i_tlb_lookup_top (
    .clk           (clk),
    .reset_i       (reset_i),
    .lookup_valid_i(lookup_valid_i),
    .lookup_req_i  (lookup_req_i),
    .resp_valid_o  (resp_valid_o),
    .resp_o        (resp_o),
    .update_req_i  (update_req_i),
    .update_i      (update_i),
    .update_ack_o  (update_ack_o)
  );

  // 100 ns clock
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic stop_run();
    $display("Some tests failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("[ERROR] %s: expected %0h actual %0h", name, expected, actual);
    stop_run();
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR: %s", msg);
    stop_run();
  endtask

  function automatic void add_row(string name, vaddr_t vaddr, asid_t asid, logic hit,
                                  logic multi, tlb_idx_t idx, paddr_t paddr, logic v, logic d);
    row_t r;
    r.vaddr         = vaddr;
    r.asid          = asid;
    r.exp.hit       = hit;
    r.exp.multi_hit = multi;
    r.exp.idx       = idx;
    r.exp.paddr     = paddr;
    r.exp.v         = v;
    r.exp.d         = d;
    rows.push_back(r);
    row_names.push_back(name);
  endfunction

  // miss: everything zero
  function automatic void add_miss(string name, vaddr_t vaddr, asid_t asid);
    add_row(name, vaddr, asid, 1'b0, 1'b0, '0, '0, 1'b0, 1'b0);
  endfunction

  function automatic void add_refill(tlb_idx_t idx, logic e, vppn_t vppn, logic huge, logic g,
                                     asid_t asid, ppn_t ppn, logic v, logic d);
    update_req_t u;
    u.idx       = idx;
    u.key.e     = e;
    u.key.vppn  = vppn;
    u.key.ps    = huge ? ps_t'(HUGE_PS) : ps_t'(SMALL_PS);
    u.key.g     = g;
    u.key.asid  = asid;
    u.value.ppn = ppn;
    u.value.v   = v;
    u.value.d   = d;
    refills.push_back(u);
    refill_at.push_back(rows.size());
  endfunction

  // every programmed vppn keeps bit 18 clear
  function automatic void build_table();
    add_miss("reset_miss_zero", 32'h0000_0000, 10'h000);
    add_miss("reset_miss_any", 32'h1234_5678, 10'h155);
    // idx 2 small private, idx 5 small global, idx 9 huge private
    add_refill(4'd2, 1'b1, 19'h01234, 1'b0, 1'b0, 10'h011, 19'h5a5a5, 1'b1, 1'b0);
    add_refill(4'd5, 1'b1, 19'h02000, 1'b0, 1'b1, 10'h000, 19'h0abcd, 1'b1, 1'b1);
    add_refill(4'd9, 1'b1, 19'h0a400, 1'b1, 1'b0, 10'h3ff, 19'h7fc00, 1'b0, 1'b1);
    // ppn 5a5a5 then offset abc
    add_row("small_hit", 32'h0246_8abc, 10'h011, 1'b1, 1'b0, 4'd2, 32'hb4b4_aabc, 1'b1, 1'b0);
    add_miss("small_wrong_asid", 32'h0246_8abc, 10'h012);
    add_miss("small_wrong_vppn", 32'h0246_a000, 10'h011);
    add_row("global_asid_a", 32'h0400_1fff, 10'h000, 1'b1, 1'b0, 4'd5, 32'h1579_bfff, 1'b1, 1'b1);
    add_row("global_asid_b", 32'h0400_1fff, 10'h2c7, 1'b1, 1'b0, 4'd5, 32'h1579_bfff, 1'b1, 1'b1);
    // vaddr 31:23 is 29, ppn 18:10 is 1ff
    add_row("huge_hit_mid", 32'h14ba_bcde, 10'h3ff, 1'b1, 1'b0, 4'd9, 32'hffba_bcde, 1'b0, 1'b1);
    add_row("huge_hit_top", 32'h14ff_ffff, 10'h3ff, 1'b1, 1'b0, 4'd9, 32'hffff_ffff, 1'b0, 1'b1);
    add_miss("huge_wrong_high", 32'h1400_0123, 10'h3ff);
    add_miss("huge_wrong_asid", 32'h14ba_bcde, 10'h3fe);
    // new translation for idx 2
    add_refill(4'd2, 1'b1, 19'h01234, 1'b0, 1'b0, 10'h011, 19'h00001, 1'b1, 1'b1);
    add_row("rewrite_hit", 32'h0246_8abc, 10'h011, 1'b1, 1'b0, 4'd2, 32'h0000_2abc, 1'b1, 1'b1);
    // idx 5 rewritten with e clear
    add_refill(4'd5, 1'b0, 19'h02000, 1'b0, 1'b1, 10'h000, 19'h0abcd, 1'b1, 1'b1);
    add_miss("disabled_miss", 32'h0400_1fff, 10'h000);
    // idx 7 is a global alias of idx 2
    add_refill(4'd7, 1'b1, 19'h01234, 1'b0, 1'b1, 10'h000, 19'h11111, 1'b0, 1'b0);
    add_row("multi_hit_low", 32'h0246_8abc, 10'h011, 1'b1, 1'b1, 4'd2, 32'h0000_2abc, 1'b1, 1'b1);
    add_row("global_only", 32'h0246_8abc, 10'h0aa, 1'b1, 1'b0, 4'd7, 32'h2222_2abc, 1'b0, 1'b0);
    // huge page at idx 0 over the same region, lowest of three hits
    add_refill(4'd0, 1'b1, 19'h01000, 1'b1, 1'b0, 10'h011, 19'h40400, 1'b1, 1'b0);
    add_row("multi_hit_huge", 32'h0246_8abc, 10'h011, 1'b1, 1'b1, 4'd0, 32'h80c6_8abc, 1'b1, 1'b0);
    add_miss("final_miss", 32'h0000_0000, 10'h000);
  endfunction

  // inputs change 10 ns after the rising edge
  task automatic next_drive();
    @(posedge clk);
    #10;
  endtask

  task automatic issue_lookup(input string name, input vaddr_t vaddr, input asid_t asid,
                              input lookup_resp_t exp);
    pending_t p;
    lookup_valid_i     = 1'b1;
    lookup_req_i.vaddr = vaddr;
    lookup_req_i.asid  = asid;
    p.resp        = exp;
    p.issue_cycle = cycle_cnt;
    pending_q.push_back(p);
    pending_names.push_back(name);
    next_drive();
  endtask

  // four-phase refill, timing of both ack edges checked
  task automatic refill(input update_req_t upd);
    int cycles;
    assert (!update_ack_o) else
      report_problem("refill ack was high before req was raised");
    update_i     = upd;
    update_req_i = 1'b1;
    cycles       = 0;
    do begin
      next_drive();
      cycles++;
    end while (!update_ack_o && cycles < 8);
    assert (update_ack_o && cycles == 2) else
      report_problem($sformatf("refill of entry %0d: ack rose after %0d cycles, expected 2",
                               upd.idx, cycles));
    // ack must hold while req stays up
    next_drive();
    assert (update_ack_o) else
      report_problem("refill ack dropped while req was still high");
    update_req_i = 1'b0;
    cycles       = 0;
    do begin
      next_drive();
      cycles++;
    end while (update_ack_o && cycles < 8);
    assert (cycles == 1) else
      report_problem($sformatf("refill of entry %0d: ack fell after %0d cycles, expected 1",
                               upd.idx, cycles));
  endtask

  task automatic check_response();
    pending_t p;
    string    name;
    if (pending_q.size() == 0) begin
      report_problem("response valid with no lookup outstanding");
    end else begin
      p    = pending_q.pop_front();
      name = pending_names.pop_front();
      // exactly two cycles after the cycle it was driven in
      assert (cycle_cnt == p.issue_cycle + 2) else
        report_mismatch({name, " latency"}, 64'(p.issue_cycle + 2), 64'(cycle_cnt));
      assert (resp_o == p.resp) else
        report_mismatch(name, 64'(p.resp), 64'(resp_o));
    end
  endtask

  // outputs sampled mid-cycle
  always @(negedge clk) begin
    if (!reset_i && resp_valid_o === 1'b1) begin
      check_response();
    end else if (pending_q.size() != 0 && cycle_cnt > pending_q[0].issue_cycle + 2) begin
      report_problem($sformatf("no response for lookup %s", pending_names[0]));
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    report_problem($sformatf("timeout after %0d cycles", WATCHDOG_CYCLES));
  end

  initial begin
    int     ref_ptr;
    vaddr_t rnd_vaddr;
    asid_t  rnd_asid;
    ref_ptr = 0;
    void'($urandom(71847));
    reset_i        = 1'b1;
    lookup_valid_i = 1'b0;
    lookup_req_i   = '0;
    update_req_i   = 1'b0;
    update_i       = '0;
    build_table();
    assert (rows.size() == NUM_ROWS && refills.size() == NUM_REFILLS) else
      report_problem("stimulus table size does not match the watchdog budget");
    repeat (3) @(posedge clk);
    #10;
    reset_i = 1'b0;
    next_drive();
    // one lookup per cycle, refills slotted in between
    for (int i = 0; i < rows.size(); i++) begin
      while (ref_ptr < refills.size() && refill_at[ref_ptr] == i) begin
        lookup_valid_i = 1'b0;
        refill(refills[ref_ptr]);
        ref_ptr++;
      end
      issue_lookup(row_names[i], rows[i].vaddr, rows[i].asid, rows[i].exp);
    end
    // bit 31 set, above every programmed page, so all miss
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rnd_vaddr = $urandom | 32'h8000_0000;
      rnd_asid  = asid_t'($urandom);
      issue_lookup($sformatf("random_%0d", i), rnd_vaddr, rnd_asid, '0);
    end
    lookup_valid_i = 1'b0;
    while (pending_q.size() != 0) begin
      next_drive();
    end
    // quiet tail, stray responses still caught
    repeat (3) next_drive();
    $display("All tests passed");
    $finish;
  end

endmodule
